// File: mmc3_pkg.sv
// MMC3 mapper shared definitions
// Bus widths, register map codes and the fixed banks
package mmc3_pkg;

	typedef logic [15:0] cpu_addr_t;  // CPU bus address
	typedef logic [13:0] ppu_addr_t;  // PPU bus address
	typedef logic [21:0] mem_addr_t;  // Mapped PRG/CHR memory address
	typedef logic [7:0]  data_t;      // CPU data byte
	typedef logic [5:0]  prg_bank_t;  // 8 KB PRG bank, 0..63
	typedef logic [7:0]  chr_bank_t;  // 1 KB CHR bank, 0..255
	typedef logic [7:0]  irq_cnt_t;   // Scanline counter and latch
	typedef logic [2:0]  bank_idx_t;  // Bank select index R0-R7

	// CPU address bits used by the register decode
	localparam int CPU_ROM_BIT    = 15;  // High for $8000-$FFFF
	localparam int CPU_REG_HI_BIT = 14;
	localparam int CPU_REG_LO_BIT = 13;
	localparam int CPU_ODD_BIT    = 0;   // Even/odd register of a pair

	// Register codes as {A14, A13, A0}
	localparam logic [2:0] REG_BANK_SELECT = 3'b000;  // $8000
	localparam logic [2:0] REG_BANK_DATA   = 3'b001;  // $8001
	localparam logic [2:0] REG_MIRROR      = 3'b010;  // $A000
	localparam logic [2:0] REG_RAM_PROT    = 3'b011;  // $A001
	localparam logic [2:0] REG_IRQ_LATCH   = 3'b100;  // $C000
	localparam logic [2:0] REG_IRQ_RELOAD  = 3'b101;  // $C001
	localparam logic [2:0] REG_IRQ_DISABLE = 3'b110;  // $E000, also acks
	localparam logic [2:0] REG_IRQ_ENABLE  = 3'b111;  // $E001

	// Fixed PRG banks
	localparam prg_bank_t PRG_BANK_LAST     = 6'd63;  // Always at $E000
	localparam prg_bank_t PRG_BANK_2ND_LAST = 6'd62;  // $C000 or $8000 by mode

	// Upper address bits of the memory regions
	localparam logic [8:0] PRG_RAM_BASE = 9'b1_1110_0000;  // Above 13 RAM bits
	localparam logic [3:0] CHR_ROM_BASE = 4'b1000;         // Above bank and 10 bits

	// A12 filter, ce cycles of low A12 before a rise counts again
	localparam int                   A12_CNT_W    = 4;
	localparam logic [A12_CNT_W-1:0] A12_COOLDOWN = 4'd15;

	localparam irq_cnt_t IRQ_CNT_ZERO = 8'd0;

endpackage

// File: mmc3_bank_if.sv
// MMC3 bank state bundle
// Bank registers and mode bits from the register file to the address mappers
`timescale 1ns/1ps

interface mmc3_bank_if;

	mmc3_pkg::chr_bank_t chr_bank [0:5];  // R0-R5, R0/R1 keep bit 0 clear
	mmc3_pkg::prg_bank_t prg_bank [0:1];  // R6, R7
	logic                prg_mode;        // Swaps $8000 and $C000
	logic                chr_invert;      // Swaps CHR halves
	logic                mirroring;       // 1 horizontal, 0 vertical
	logic                ram_enable;      // PRG-RAM chip enable
	logic                ram_protect;     // PRG-RAM write protect

	modport regs (
		output chr_bank, prg_bank, prg_mode, chr_invert,
		output mirroring, ram_enable, ram_protect
	);

	modport map (
		input chr_bank, prg_bank, prg_mode, chr_invert,
		input mirroring, ram_enable, ram_protect
	);

endinterface

// File: mmc3_irq_if.sv
// MMC3 IRQ control bundle
// Latch, enable and strobes from the register file to the scanline counter
`timescale 1ns/1ps

interface mmc3_irq_if;

	mmc3_pkg::irq_cnt_t irq_latch;   // Reload value from $C000
	logic               irq_enable;  // Set by $E001, cleared by $E000
	logic               reload_stb;  // One clk after a $C001 write
	logic               ack_stb;     // One clk after a $E000 write

	modport regs (
		output irq_latch, irq_enable, reload_stb, ack_stb
	);

	modport counter (
		input irq_latch, irq_enable, reload_stb, ack_stb
	);

endinterface

// File: mmc3_regs.sv
// MMC3 CPU register file
// Decodes writes at $8000-$FFFF and holds bank, mode, RAM and IRQ settings
`timescale 1ns/1ps

module mmc3_regs (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                ce_i,         // M2 enable
	input  mmc3_pkg::cpu_addr_t cpu_addr_i,
	input  mmc3_pkg::data_t     cpu_data_i,
	input  logic                cpu_write_i,
	mmc3_bank_if.regs           bank_o,
	mmc3_irq_if.regs            irq_o
);

	logic                wr_en;     // Qualified write to mapper space
	logic [2:0]          reg_sel;   // {A14, A13, A0}
	mmc3_pkg::bank_idx_t bank_sel;  // Target of next $8001 write

	assign wr_en   = ce_i && cpu_write_i && cpu_addr_i[mmc3_pkg::CPU_ROM_BIT];
	assign reg_sel = {cpu_addr_i[mmc3_pkg::CPU_REG_HI_BIT],
		cpu_addr_i[mmc3_pkg::CPU_REG_LO_BIT], cpu_addr_i[mmc3_pkg::CPU_ODD_BIT]};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bank_sel            <= '0;
			bank_o.prg_bank[0]  <= '0;
			bank_o.prg_bank[1]  <= '0;
			bank_o.prg_mode     <= 1'b0;
			bank_o.chr_invert   <= 1'b0;
			bank_o.mirroring    <= 1'b0;  // Vertical
			bank_o.ram_enable   <= 1'b0;
			bank_o.ram_protect  <= 1'b0;
			irq_o.irq_latch     <= mmc3_pkg::IRQ_CNT_ZERO;
			irq_o.irq_enable    <= 1'b0;
			irq_o.reload_stb    <= 1'b0;
			irq_o.ack_stb       <= 1'b0;
			for (int i = 0; i < 6; i++) begin
				bank_o.chr_bank[i] <= '0;
			end
		end else begin
			// Strobes live for the single clk after the write
			irq_o.reload_stb <= wr_en && (reg_sel == mmc3_pkg::REG_IRQ_RELOAD);
			irq_o.ack_stb    <= wr_en && (reg_sel == mmc3_pkg::REG_IRQ_DISABLE);
			if (wr_en) begin
				case (reg_sel)
					mmc3_pkg::REG_BANK_SELECT: begin
						bank_o.chr_invert <= cpu_data_i[7];
						bank_o.prg_mode   <= cpu_data_i[6];
						bank_sel          <= cpu_data_i[2:0];
					end
					mmc3_pkg::REG_BANK_DATA: begin
						case (bank_sel)
							3'd0, 3'd1: bank_o.chr_bank[bank_sel] <= {cpu_data_i[7:1], 1'b0};  // 2 KB
							3'd2, 3'd3, 3'd4, 3'd5: bank_o.chr_bank[bank_sel] <= cpu_data_i;
							3'd6: bank_o.prg_bank[0] <= cpu_data_i[5:0];
							3'd7: bank_o.prg_bank[1] <= cpu_data_i[5:0];
						endcase
					end
					mmc3_pkg::REG_MIRROR: bank_o.mirroring <= cpu_data_i[0];
					mmc3_pkg::REG_RAM_PROT: begin
						bank_o.ram_enable  <= cpu_data_i[7];
						bank_o.ram_protect <= cpu_data_i[6];
					end
					mmc3_pkg::REG_IRQ_LATCH:   irq_o.irq_latch  <= cpu_data_i;
					mmc3_pkg::REG_IRQ_DISABLE: irq_o.irq_enable <= 1'b0;
					mmc3_pkg::REG_IRQ_ENABLE:  irq_o.irq_enable <= 1'b1;
					default: ;  // Reload only raises its strobe
				endcase
			end
		end
	end

	// A CPU write is one clk wide, so neither strobe may be stretched
	assert property (@(posedge clk) disable iff (!arst_n_i)
		irq_o.reload_stb |=> !irq_o.reload_stb)
		else $error("reload_stb high for two clocks");

	assert property (@(posedge clk) disable iff (!arst_n_i)
		irq_o.ack_stb |=> !irq_o.ack_stb)
		else $error("ack_stb high for two clocks");

endmodule

// File: mmc3_irq.sv
// MMC3 scanline IRQ counter
// Filters PPU A12 rises and counts scanlines down to an IRQ
`timescale 1ns/1ps

module mmc3_irq (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        ce_i,       // M2 enable
	input  logic        ppu_a12_i,  // PPU address bit 12
	mmc3_irq_if.counter ctl_i,
	output logic        irq_o
);

	logic [mmc3_pkg::A12_CNT_W-1:0] a12_cnt;      // Low-time cooldown
	logic                           a12_event;    // Filtered A12 rise
	logic                           reload_pend;  // $C001 seen, not yet used
	mmc3_pkg::irq_cnt_t             irq_cnt;
	mmc3_pkg::irq_cnt_t             cnt_next;

	assign a12_event = ce_i && ppu_a12_i && (a12_cnt == '0);
	assign cnt_next  = (irq_cnt == mmc3_pkg::IRQ_CNT_ZERO || reload_pend)
		? ctl_i.irq_latch : irq_cnt - 8'd1;

	// Held while A12 is high, runs down on ce cycles while low
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			a12_cnt <= '0;
		end else if (ppu_a12_i) begin
			a12_cnt <= mmc3_pkg::A12_COOLDOWN;
		end else if (ce_i && a12_cnt != '0) begin
			a12_cnt <= a12_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			irq_cnt     <= mmc3_pkg::IRQ_CNT_ZERO;
			reload_pend <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			if (ctl_i.ack_stb) begin
				irq_o <= 1'b0;
			end
			if (a12_event) begin
				irq_cnt     <= cnt_next;
				reload_pend <= 1'b0;  // Event wins over a same-clk reload
				if (cnt_next == mmc3_pkg::IRQ_CNT_ZERO && ctl_i.irq_enable) begin
					irq_o <= 1'b1;  // Normal behaviour, fires on every zero
				end
			end else if (ctl_i.reload_stb) begin
				reload_pend <= 1'b1;
			end
		end
	end

	// The enable comes from the register file one clk ahead of the flag
	assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(irq_o) |-> $past(ctl_i.irq_enable))
		else $error("irq_o rose while irq_enable was low");

endmodule

// File: mmc3_prg_map.sv
// MMC3 PRG address mapper
// Maps 8 KB PRG-ROM windows and the $6000-$7FFF PRG-RAM window
`timescale 1ns/1ps

module mmc3_prg_map (
	input  mmc3_pkg::cpu_addr_t cpu_addr_i,
	input  logic                cpu_write_i,
	mmc3_bank_if.map            bank_i,
	output mmc3_pkg::mem_addr_t prg_addr_o,
	output logic                prg_allow_o   // Access may proceed
);

	mmc3_pkg::prg_bank_t rom_bank;  // Bank for the current 8 KB window
	logic                is_ram;    // Allowed PRG-RAM access

	always_comb begin
		case ({cpu_addr_i[mmc3_pkg::CPU_REG_HI_BIT], cpu_addr_i[mmc3_pkg::CPU_REG_LO_BIT]})
			2'b00: rom_bank = bank_i.prg_mode ? mmc3_pkg::PRG_BANK_2ND_LAST
				: bank_i.prg_bank[0];  // $8000, R6 or 62
			2'b01: rom_bank = bank_i.prg_bank[1];  // $A000 always R7
			2'b10: rom_bank = bank_i.prg_mode ? bank_i.prg_bank[0]
				: mmc3_pkg::PRG_BANK_2ND_LAST;  // $C000, 62 or R6
			default: rom_bank = mmc3_pkg::PRG_BANK_LAST;  // $E000
		endcase
	end

	// Write while protected falls outside the window
	assign is_ram = (cpu_addr_i[15:13] == 3'b011) && bank_i.ram_enable
		&& !(bank_i.ram_protect && cpu_write_i);

	assign prg_addr_o = is_ram ? {mmc3_pkg::PRG_RAM_BASE, cpu_addr_i[12:0]}
		: {3'b000, rom_bank, cpu_addr_i[12:0]};

	// ROM is read only
	assign prg_allow_o = (cpu_addr_i[mmc3_pkg::CPU_ROM_BIT] && !cpu_write_i) || is_ram;

endmodule

// File: mmc3_chr_map.sv
// MMC3 CHR address mapper
// Picks 1/2 KB CHR-ROM banks with A12 inversion and drives nametable mirroring
`timescale 1ns/1ps

module mmc3_chr_map (
	input  mmc3_pkg::ppu_addr_t ppu_addr_i,
	mmc3_bank_if.map            bank_i,
	output mmc3_pkg::mem_addr_t chr_addr_o,
	output logic                vram_a10_o,  // CIRAM A10
	output logic                vram_ce_o    // Nametable access
);

	logic                chr_side;  // 0 for the 2 KB half
	mmc3_pkg::chr_bank_t chr_bank;

	assign chr_side = ppu_addr_i[12] ^ bank_i.chr_invert;

	always_comb begin
		case ({chr_side, ppu_addr_i[11:10]})
			3'b000, 3'b001: chr_bank = {bank_i.chr_bank[0][7:1], ppu_addr_i[10]};  // R0, 2 KB
			3'b010, 3'b011: chr_bank = {bank_i.chr_bank[1][7:1], ppu_addr_i[10]};  // R1, 2 KB
			3'b100: chr_bank = bank_i.chr_bank[2];
			3'b101: chr_bank = bank_i.chr_bank[3];
			3'b110: chr_bank = bank_i.chr_bank[4];
			default: chr_bank = bank_i.chr_bank[5];
		endcase
	end

	assign chr_addr_o = {mmc3_pkg::CHR_ROM_BASE, chr_bank, ppu_addr_i[9:0]};

	assign vram_a10_o = bank_i.mirroring ? ppu_addr_i[11] : ppu_addr_i[10];  // Horizontal uses A11
	assign vram_ce_o  = ppu_addr_i[13];

endmodule

// File: mmc3_top.sv
// MMC3 mapper top level
// Joins the register file, IRQ counter and the PRG and CHR mappers
`timescale 1ns/1ps

module mmc3_top (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                ce_i,         // M2 enable
	input  mmc3_pkg::cpu_addr_t cpu_addr_i,
	input  mmc3_pkg::data_t     cpu_data_i,
	input  logic                cpu_write_i,
	input  mmc3_pkg::ppu_addr_t ppu_addr_i,
	output mmc3_pkg::mem_addr_t prg_addr_o,
	output logic                prg_allow_o,
	output mmc3_pkg::mem_addr_t chr_addr_o,
	output logic                vram_a10_o,
	output logic                vram_ce_o,
	output logic                irq_o
);

	mmc3_bank_if bank_if ();  // Banks and modes to both mappers
	mmc3_irq_if  irq_if ();   // IRQ control to the counter

	mmc3_regs mmc3_regs_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ce_i        (ce_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_write_i (cpu_write_i),
		.bank_o      (bank_if.regs),
		.irq_o       (irq_if.regs)
	);

	mmc3_irq mmc3_irq_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.ce_i      (ce_i),
		.ppu_a12_i (ppu_addr_i[12]),
		.ctl_i     (irq_if.counter),
		.irq_o     (irq_o)
	);

	mmc3_prg_map mmc3_prg_map_i (
		.cpu_addr_i  (cpu_addr_i),
		.cpu_write_i (cpu_write_i),
		.bank_i      (bank_if.map),
		.prg_addr_o  (prg_addr_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc3_chr_map mmc3_chr_map_i (
		.ppu_addr_i (ppu_addr_i),
		.bank_i     (bank_if.map),
		.chr_addr_o (chr_addr_o),
		.vram_a10_o (vram_a10_o),
		.vram_ce_o  (vram_ce_o)
	);

endmodule

// File: tb_mmc3.sv
// MMC3 mapper testbench
// Checks PRG/CHR banking, mirroring, PRG-RAM and the scanline IRQ
`timescale 1ns/1ps

module tb_mmc3;

	localparam int HALF_PERIOD    = 20;  // 40 ns clock
	localparam int RESET_CYCLES   = 4;
	localparam int A12_LOW_CYCLES = 16;  // Covers the A12 cooldown

	logic                clk;
	logic                arst_n_i;
	logic                ce_i;
	mmc3_pkg::cpu_addr_t cpu_addr_i;
	mmc3_pkg::data_t     cpu_data_i;
	logic                cpu_write_i;
	mmc3_pkg::ppu_addr_t ppu_addr_i;
	mmc3_pkg::mem_addr_t prg_addr_o;
	logic                prg_allow_o;
	mmc3_pkg::mem_addr_t chr_addr_o;
	logic                vram_a10_o;
	logic                vram_ce_o;
	logic                irq_o;

	integer              seed = 32'h8055102b;
	logic                mirror_h;      // Expected mirroring, 1 horizontal
	logic                irq_at_edge;   // irq_o half a clk after the A12 edge
	mmc3_pkg::chr_bank_t chr_r [0:5];   // Raw bytes written to R0-R5
	mmc3_pkg::prg_bank_t prg_r [0:1];   // R6, R7

	mmc3_top mmc3_top_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.ce_i        (ce_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_data_i  (cpu_data_i),
		.cpu_write_i (cpu_write_i),
		.ppu_addr_i  (ppu_addr_i),
		.prg_addr_o  (prg_addr_o),
		.prg_allow_o (prg_allow_o),
		.chr_addr_o  (chr_addr_o),
		.vram_a10_o  (vram_a10_o),
		.vram_ce_o   (vram_ce_o),
		.irq_o       (irq_o)
	);

	always #HALF_PERIOD clk = ~clk;

	// Nametable select tracks PPU A13 on every clock
	assert property (@(posedge clk) disable iff (!arst_n_i) vram_ce_o == ppu_addr_i[13])
		else begin
			$display("MISMATCH vram_ce_o: got 0x%0h, expected 0x%0h",
				$sampled(vram_ce_o), $sampled(ppu_addr_i[13]));
			$display("Result: FAILED");
			$fatal(1);
		end

	assert property (@(posedge clk) disable iff (!arst_n_i)
		vram_a10_o == (mirror_h ? ppu_addr_i[11] : ppu_addr_i[10]))
		else begin
			$display("MISMATCH vram_a10_o: got 0x%0h, expected 0x%0h", $sampled(vram_a10_o),
				$sampled(mirror_h ? ppu_addr_i[11] : ppu_addr_i[10]));
			$display("Result: FAILED");
			$fatal(1);
		end

	task automatic check_eq(input string name, input logic [21:0] got, input logic [21:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic cpu_write(input mmc3_pkg::cpu_addr_t addr, input mmc3_pkg::data_t data);
		@(negedge clk);
		cpu_addr_i  = addr;
		cpu_data_i  = data;
		cpu_write_i = 1'b1;
		@(negedge clk);  // Taken on the posedge in between
		cpu_write_i = 1'b0;
	endtask

	// Holds a CPU access and settles mid low phase
	task automatic cpu_access(input mmc3_pkg::cpu_addr_t addr, input logic wr);
		@(negedge clk);
		cpu_addr_i  = addr;
		cpu_write_i = wr;
		#(HALF_PERIOD / 2);
	endtask

	task automatic ppu_access(input mmc3_pkg::ppu_addr_t addr);
		@(negedge clk);
		ppu_addr_i = addr;
		#(HALF_PERIOD / 2);
	endtask

	task automatic a12_pulse();
		@(negedge clk);
		ppu_addr_i = 14'h1000;
		@(negedge clk);
		irq_at_edge = irq_o;  // Counter edge just passed
		ppu_addr_i  = '0;
		repeat (A12_LOW_CYCLES) @(negedge clk);
	endtask

	task automatic wait_irq(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (irq_o !== level) begin
			if (cycles == limit) begin
				$display("Timeout: irq_o did not reach %0b within %0d cycles", level, limit);
				$display("Result: FAILED");
				$fatal(1);
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// Mode 0 table, mode 1 swaps $8000 and $C000
	task automatic check_prg(input logic mode);
		cpu_access(16'h8abc, 1'b0);
		check_eq("prg_addr_o", prg_addr_o,
			{3'b000, mode ? mmc3_pkg::PRG_BANK_2ND_LAST : prg_r[0], 13'h0abc});
		check_eq("prg_allow_o", prg_allow_o, 1'b1);
		cpu_access(16'hA123, 1'b0);
		check_eq("prg_addr_o", prg_addr_o, {3'b000, prg_r[1], 13'h0123});
		cpu_access(16'hD555, 1'b0);
		check_eq("prg_addr_o", prg_addr_o,
			{3'b000, mode ? prg_r[0] : mmc3_pkg::PRG_BANK_2ND_LAST, 13'h1555});
		cpu_access(16'hE001, 1'b0);
		check_eq("prg_addr_o", prg_addr_o, {3'b000, mmc3_pkg::PRG_BANK_LAST, 13'h0001});
	endtask

	function automatic mmc3_pkg::mem_addr_t chr_expect(input logic [2:0] slot, input logic inv);
		mmc3_pkg::chr_bank_t bank;
		if (slot[2] ^ inv) begin
			bank = chr_r[2 + slot[1:0]];  // 1 KB side
		end else begin
			bank = {chr_r[slot[1]][7:1], slot[0]};  // 2 KB pair, A10 low bit
		end
		return {mmc3_pkg::CHR_ROM_BASE, bank, 10'h2a7};
	endfunction

	task automatic check_chr(input logic inv);
		logic [2:0] slot;
		for (int s = 0; s < 8; s++) begin
			slot = s[2:0];
			ppu_access({1'b0, slot, 10'h2a7});
			check_eq("chr_addr_o", chr_addr_o, chr_expect(slot, inv));
		end
	endtask

	initial begin
		mmc3_pkg::data_t val;
		int              irq_n;
		int              cycles;
		clk         = 1'b0;
		arst_n_i    = 1'b0;
		ce_i        = 1'b1;
		cpu_addr_i  = '0;
		cpu_data_i  = '0;
		cpu_write_i = 1'b0;
		ppu_addr_i  = '0;
		mirror_h    = 1'b0;
		irq_at_edge = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n_i = 1'b1;

		// Reset state
		cpu_access(16'hE456, 1'b0);
		check_eq("prg_addr_o", prg_addr_o, {3'b000, 6'd63, 13'h0456});
		cpu_access(16'hC456, 1'b0);
		check_eq("prg_addr_o", prg_addr_o, {3'b000, 6'd62, 13'h0456});
		check_eq("irq_o", irq_o, 1'b0);
		cpu_access(16'h6000, 1'b0);
		check_eq("prg_allow_o", prg_allow_o, 1'b0);

		for (int i = 0; i < 2; i++) begin
			val      = $random(seed);
			prg_r[i] = val[5:0];  // Upper two bits ignored
			cpu_write(16'h8000, 8'd6 + i);
			cpu_write(16'h8001, val);
		end
		check_prg(1'b0);
		cpu_write(16'h8000, 8'h40);
		check_prg(1'b1);

		for (int i = 0; i < 6; i++) begin
			val      = $random(seed);
			chr_r[i] = val;
			cpu_write(16'h8000, i);
			cpu_write(16'h8001, val);
		end
		check_chr(1'b0);
		cpu_write(16'h8000, 8'h80);
		check_chr(1'b1);

		// Nametable sweep, assertions do the checking
		cpu_write(16'hA000, 8'h01);
		mirror_h = 1'b1;
		for (int s = 0; s < 4; s++) ppu_access({2'b10, s[1:0], 10'h0c3});
		cpu_write(16'hA000, 8'h00);
		mirror_h = 1'b0;
		for (int s = 0; s < 4; s++) ppu_access({2'b10, s[1:0], 10'h0c3});
		ppu_access('0);

		cpu_write(16'hA001, 8'h80);  // RAM on, unprotected
		cpu_access(16'h6123, 1'b0);
		check_eq("prg_allow_o", prg_allow_o, 1'b1);
		check_eq("prg_addr_o", prg_addr_o, {mmc3_pkg::PRG_RAM_BASE, 13'h0123});
		cpu_access(16'h6123, 1'b1);
		check_eq("prg_allow_o", prg_allow_o, 1'b1);
		check_eq("prg_addr_o", prg_addr_o, {mmc3_pkg::PRG_RAM_BASE, 13'h0123});
		cpu_write(16'hA001, 8'hC0);  // Protected
		cpu_access(16'h7ffe, 1'b1);
		check_eq("prg_allow_o", prg_allow_o, 1'b0);
		cpu_access(16'h7ffe, 1'b0);
		check_eq("prg_allow_o", prg_allow_o, 1'b1);
		check_eq("prg_addr_o", prg_addr_o, {mmc3_pkg::PRG_RAM_BASE, 13'h1ffe});

		repeat (A12_LOW_CYCLES) @(negedge clk);  // Let the A12 filter expire
		irq_n = {$random(seed)} % 7 + 1;
		cpu_write(16'hC000, irq_n);
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		for (int p = 0; p < irq_n; p++) begin
			a12_pulse();
			check_eq("irq_o", irq_at_edge, 1'b0);
		end
		a12_pulse();
		check_eq("irq_o", irq_at_edge, 1'b1);
		cpu_write(16'hE000, 8'h00);
		wait_irq(1'b0, 4, cycles);
		check_eq("irq_o clear delay", cycles, 1);

		// Latch zero fires on every edge
		cpu_write(16'hC000, 8'h00);
		for (int p = 0; p < 3; p++) begin
			cpu_write(16'hE001, 8'h00);
			a12_pulse();
			check_eq("irq_o", irq_at_edge, 1'b1);
			cpu_write(16'hE000, 8'h00);
			wait_irq(1'b0, 4, cycles);
			check_eq("irq_o clear delay", cycles, 1);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: compile.f
mmc3_pkg.sv
mmc3_bank_if.sv
mmc3_irq_if.sv
mmc3_regs.sv
mmc3_irq.sv
mmc3_prg_map.sv
mmc3_chr_map.sv
mmc3_top.sv
tb_mmc3.sv

// File: Bender.yml
package:
  name: mmc3

sources:
  - mmc3_pkg.sv
  - mmc3_bank_if.sv
  - mmc3_irq_if.sv
  - mmc3_regs.sv
  - mmc3_irq.sv
  - mmc3_prg_map.sv
  - mmc3_chr_map.sv
  - mmc3_top.sv
  - target: test
    files:
      - tb_mmc3.sv
